//--- dv/pipe_ctrl_checker.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_ctrl_checker
	import core_arch_pkg::*;
(
	input  logic        iCLOCK,
	input  logic        inRESET,
	input  logic        reset_sync,
	input  word_t       jump_addr,
	input  logic        branch_valid,
	input  logic        return_valid,
	input  logic        reload_valid,
	input  logic        irq_req,
	input  irq_num_t    irq_num,
	input  logic        irq_ack,
	input  word_t       sysreg_psr,
	input  word_t       sysreg_pcr,
	input  word_t       sysreg_ppcr,
	input  word_t       sysreg_idtr,
	input  logic        irq_lock,
	input  logic        ldst_use,
	input  logic        ldst_req,
	input  ldst_order_t ldst_order,
	input  logic        ldst_rw,
	input  word_t       ldst_addr,
	input  word_t       ldst_data,
	input  logic        ldst_busy,
	input  logic        ldst_valid,
	input  logic        event_hold,
	input  logic        event_start,
	input  logic        event_irq_front2back,
	input  logic        event_irq_back2front,
	input  logic        event_end,
	input  logic        pcr_set,
	input  word_t       pcr,
	input  logic        ppcr_set,
	input  word_t       ppcr
);

	localparam int M_IDLE = 0;
	localparam int M_SHORT = 1;
	localparam int M_IRQ = 2;
	// Longest plausible wait for a handler with random busy and delay
	localparam int ACK_LIMIT = 60;

	int errors = 0;
	int checks = 0;
	int m_state;
	int irq_cycles;
	logic m_hold, m_start, m_f2b, m_b2f, m_end, m_ack;
	logic m_pcr_set, m_ppcr_set;
	word_t m_pcr, m_ppcr;
	logic m_pending, m_use, m_req, m_done;
	word_t m_addr, m_handler;
	irq_num_t m_num;
	logic irq_ok, idle, go_irq, go_jump, go_ret, go;
	logic fin_irq, fin_short, accepted, resp;

	// Memory answers with the address halves exchanged
	function automatic word_t expected_rdata(input word_t addr);
		return {addr[15:0], addr[31:16]};
	endfunction

	task automatic check_value(input string name, input word_t exp, input word_t got);
		checks++;
		if (exp !== got) begin
			errors++;
			$display("ERR %0t: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	// Reference model, advanced on each rising edge with the pre-edge inputs
	always @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET || reset_sync) begin
			m_state = M_IDLE;
			{m_hold, m_start, m_f2b, m_b2f, m_end, m_ack} = '0;
			{m_pcr_set, m_ppcr_set, m_pending, m_use, m_req, m_done} = '0;
			m_pcr = '0;
		end else begin
			irq_ok = irq_req && !irq_lock && sysreg_psr[PSR_IRQ_ENABLE_BIT];
			idle = (m_state == M_IDLE);
			go_irq = idle && irq_ok;
			go_jump = idle && (branch_valid || (!irq_ok && reload_valid));
			go_ret = idle && !irq_ok && !branch_valid && !reload_valid && return_valid;
			go = go_irq || go_jump || go_ret;
			fin_irq = (m_state == M_IRQ) && m_done;
			fin_short = (m_state == M_SHORT);
			accepted = m_req && !ldst_busy;
			resp = ldst_valid && (accepted || !m_req);

			if (idle) begin
				m_hold = go;
			end
			m_start = go;
			m_f2b = go_irq;
			m_b2f = go_ret;
			m_end = fin_short || fin_irq;
			m_ack = fin_irq;
			m_ppcr_set = fin_irq;
			if (fin_irq) begin
				m_ppcr = sysreg_pcr;
			end

			if (go_jump) begin
				m_pcr_set = 1'b1;
				m_pcr = jump_addr;
			end else if (fin_irq) begin
				m_pcr_set = 1'b1;
				m_pcr = m_handler;
			end else if (go_ret) begin
				m_pcr_set = 1'b1;
				m_pcr = sysreg_ppcr;
			end else if (idle && !go) begin
				m_pcr_set = 1'b0;
				m_pcr = '0;
			end

			// Descriptor read
			m_done = 1'b0;
			if (m_pending) begin
				m_use = 1'b1;
				m_req = 1'b1;
				m_addr = sysreg_idtr + 32'(m_num) * IDT_ENTRY_BYTES;
			end else if (m_use) begin
				if (accepted) begin
					m_req = 1'b0;
				end
				if (resp) begin
					m_use = 1'b0;
					m_done = 1'b1;
					m_handler = expected_rdata(m_addr);
				end
			end
			m_pending = go_irq;
			if (go_irq) begin
				m_num = irq_num;
			end

			if (idle) begin
				m_state = go_irq ? M_IRQ : (go ? M_SHORT : M_IDLE);
			end else if (fin_short || fin_irq) begin
				m_state = M_IDLE;
			end
		end
	end

	// Outputs are compared in the middle of the cycle
	always @(negedge iCLOCK) begin
		if (inRESET) begin
			check_value("event_hold", m_hold, event_hold);
			check_value("event_start", m_start, event_start);
			check_value("event_irq_front2back", m_f2b, event_irq_front2back);
			check_value("event_irq_back2front", m_b2f, event_irq_back2front);
			check_value("event_end", m_end, event_end);
			check_value("irq_ack", m_ack, irq_ack);
			check_value("ldst_use", m_use, ldst_use);
			check_value("ldst_req", m_req, ldst_req);
			check_value("pcr_set", m_pcr_set, pcr_set);
			check_value("pcr", m_pcr, pcr);
			check_value("ppcr_set", m_ppcr_set, ppcr_set);
			if (m_ppcr_set) begin
				check_value("ppcr", m_ppcr, ppcr);
			end
			if (m_req) begin
				check_value("ldst_addr", m_addr, ldst_addr);
				check_value("ldst_rw", LDST_READ, ldst_rw);
				check_value("ldst_order", LDST_WORD, ldst_order);
				check_value("ldst_data", '0, ldst_data);
			end
			irq_cycles = (m_state == M_IRQ) ? irq_cycles + 1 : 0;
			if (irq_cycles == ACK_LIMIT) begin
				errors++;
				$display("Interrupt at time %0t was not acknowledged within %0d cycles",
					$time, ACK_LIMIT);
			end
		end else begin
			irq_cycles = 0;
		end
	end

endmodule

`default_nettype wire

//--- dv/tb_pipe_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pipe_ctrl
	import core_arch_pkg::*;
();

	localparam int NUM_REQ = 200;

	logic iCLOCK, inRESET, reset_sync;
	word_t jump_addr;
	logic branch_valid, return_valid, reload_valid;
	logic irq_req, irq_ack, irq_lock;
	irq_num_t irq_num;
	word_t sysreg_psr, sysreg_pcr, sysreg_ppcr, sysreg_idtr;
	logic ldst_use, ldst_req, ldst_rw, ldst_busy, ldst_valid;
	ldst_order_t ldst_order;
	word_t ldst_addr, ldst_data, ldst_rdata;
	logic event_hold, event_start, event_irq_front2back, event_irq_back2front, event_end;
	logic pcr_set, ppcr_set;
	word_t pcr, ppcr;

	integer seed;
	int req_count;
	logic mem_wait;
	int mem_cnt;
	int delay;
	word_t mem_addr;

	pipe_ctrl_top UUT (.*);

	pipe_ctrl_checker u_checker (.*);

	function automatic word_t swap_halves(input word_t addr);
		return {addr[15:0], addr[31:16]};
	endfunction

	task automatic issue_request();
		int unsigned kind;
		word_t psr_val;
		word_t mix;
		kind = $unsigned($random(seed)) % 6;
		// Random mix of simultaneous requests for the last kind
		mix = $random(seed);
		psr_val = $random(seed);
		psr_val[PSR_IRQ_ENABLE_BIT] = ($unsigned($random(seed)) % 5) != 0;
		sysreg_psr <= psr_val;
		jump_addr <= $random(seed);
		sysreg_pcr <= $random(seed);
		sysreg_ppcr <= $random(seed);
		sysreg_idtr <= $random(seed);
		irq_num <= irq_num_t'($random(seed));
		irq_lock <= ($unsigned($random(seed)) % 5) == 0;
		branch_valid <= (kind == 0) || (kind == 4) || ((kind == 5) && mix[0]);
		reload_valid <= (kind == 1) || ((kind == 5) && mix[1]);
		return_valid <= (kind == 2) || ((kind == 5) && mix[2]);
		irq_req <= (kind == 3) || (kind == 4) || ((kind == 5) && mix[3]);
	endtask

	// Occasional stray branch lands while the machine is busy
	task automatic clear_requests();
		branch_valid <= ($unsigned($random(seed)) % 4) == 0;
		reload_valid <= 1'b0;
		return_valid <= 1'b0;
		irq_req <= 1'b0;
	endtask

	initial begin
		iCLOCK = 1'b0;
		forever #5 iCLOCK = ~iCLOCK;
	end

	// Memory side of the load/store port
	always @(posedge iCLOCK) begin
		ldst_valid <= 1'b0;
		ldst_busy <= ($unsigned($random(seed)) % 4) == 0;
		if (!inRESET || reset_sync) begin
			mem_wait <= 1'b0;
			mem_cnt <= 0;
		end else if (mem_wait) begin
			if (mem_cnt == 0) begin
				ldst_valid <= 1'b1;
				ldst_rdata <= swap_halves(mem_addr);
				mem_wait <= 1'b0;
			end else begin
				mem_cnt <= mem_cnt - 1;
			end
		end else if (ldst_req && !ldst_busy) begin
			delay = $unsigned($random(seed)) % 6;
			if (delay == 0) begin
				ldst_valid <= 1'b1;
				ldst_rdata <= swap_halves(ldst_addr);
			end else begin
				mem_wait <= 1'b1;
				mem_cnt <= delay - 1;
				mem_addr <= ldst_addr;
			end
		end
	end

	initial begin
		seed = 32'h3a743fd6;
		inRESET = 1'b0;
		reset_sync = 1'b0;
		{branch_valid, return_valid, reload_valid, irq_req, irq_lock} = '0;
		{jump_addr, sysreg_psr, sysreg_pcr, sysreg_ppcr, sysreg_idtr} = '0;
		irq_num = '0;
		ldst_busy = 1'b0;
		ldst_valid = 1'b0;
		ldst_rdata = '0;
		mem_wait = 1'b0;
		mem_cnt = 0;
		repeat (4) @(posedge iCLOCK);
		inRESET <= 1'b1;
		@(posedge iCLOCK);
		for (req_count = 0; req_count < NUM_REQ; req_count++) begin
			issue_request();
			@(posedge iCLOCK);
			clear_requests();
			// Synchronous reset in the middle of some sequences
			if (req_count % 23 == 11) begin
				@(posedge iCLOCK);
				reset_sync <= 1'b1;
				@(posedge iCLOCK);
				reset_sync <= 1'b0;
			end
			@(posedge iCLOCK);
			branch_valid <= 1'b0;
			while (event_hold) begin
				@(posedge iCLOCK);
			end
			repeat ($unsigned($random(seed)) % 3) @(posedge iCLOCK);
		end
		repeat (20) @(posedge iCLOCK);
		$display("checks: %0d, errors: %0d", u_checker.checks, u_checker.errors);
		if (u_checker.errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		repeat (NUM_REQ * 20 + 200) @(posedge iCLOCK);
		$display("Watchdog expired before all requests were served");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/core_arch_pkg.sv
`default_nettype none

package core_arch_pkg;

	// Data and address word of the core
	typedef logic [31:0] word_t;

	// External interrupt number
	typedef logic [6:0] irq_num_t;

	// Load/store access size
	typedef enum logic [1:0] {
		LDST_BYTE = 2'b00,
		LDST_HALF = 2'b01,
		LDST_WORD = 2'b10,
		LDST_NONE = 2'b11
	} ldst_order_t;

	// Interrupt enable flag in the PSR
	localparam int PSR_IRQ_ENABLE_BIT = 2;

	// One descriptor table entry, handler address in the first word
	localparam int IDT_ENTRY_BYTES = 8;

	// Read/write line level for a read access
	localparam logic LDST_READ = 1'b0;

endpackage

`default_nettype wire

//--- hdl/irq_vector_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module irq_vector_fetch
	import core_arch_pkg::*;
(
	input  logic        iCLOCK,
	input  logic        inRESET,
	input  logic        reset_sync,
	input  logic        start,
	input  irq_num_t    irq_num,
	input  word_t       idtr,
	output logic        done,
	output word_t       handler,
	output logic        ldst_use,
	output logic        ldst_req,
	output ldst_order_t ldst_order,
	output logic        ldst_rw,
	output word_t       ldst_addr,
	output word_t       ldst_data,
	input  logic        ldst_busy,
	input  logic        ldst_valid,
	input  word_t       ldst_rdata
);

	logic pending;
	irq_num_t num_q;
	logic accepted;

	// Request taken by the port at this edge
	assign accepted = ldst_req && !ldst_busy;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pending <= 1'b0;
			ldst_use <= 1'b0;
			ldst_req <= 1'b0;
			done <= 1'b0;
		end else if (reset_sync) begin
			pending <= 1'b0;
			ldst_use <= 1'b0;
			ldst_req <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			pending <= start;
			if (pending) begin
				ldst_use <= 1'b1;
				ldst_req <= 1'b1;
			end else if (ldst_use) begin
				if (accepted) begin
					ldst_req <= 1'b0;
				end
				// Response may come with the accepting edge or any later one
				if (ldst_valid && (accepted || !ldst_req)) begin
					ldst_use <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// Interrupt number sampled with the start strobe
	always_ff @(posedge iCLOCK) begin
		if (start) begin
			num_q <= irq_num;
		end
	end

	// Descriptor address, held through busy
	always_ff @(posedge iCLOCK) begin
		if (pending) begin
			ldst_addr <= idtr + word_t'(num_q) * word_t'(IDT_ENTRY_BYTES);
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (ldst_use && ldst_valid && (accepted || !ldst_req)) begin
			handler <= ldst_rdata;
		end
	end

	// Word read only
	assign ldst_order = LDST_WORD;
	assign ldst_rw = LDST_READ;
	assign ldst_data = '0;

endmodule

`default_nettype wire

//--- hdl/pipe_ctrl_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_ctrl_fsm
	import core_arch_pkg::*;
	import pipe_ctrl_pkg::*;
(
	input  logic        iCLOCK,
	input  logic        inRESET,
	input  logic        reset_sync,
	input  logic        branch_valid,
	input  logic        return_valid,
	input  logic        reload_valid,
	input  logic        irq_req,
	input  logic        irq_lock,
	input  word_t       sysreg_psr,
	input  logic        fetch_done,
	output logic        fetch_start,
	redirect_if.ctrl    redirect,
	output logic        event_hold,
	output logic        event_start,
	output logic        event_irq_front2back,
	output logic        event_irq_back2front,
	output logic        event_end,
	output logic        irq_ack
);

	ctrl_state_t state;
	ctrl_state_t next_state;
	logic in_idle;
	logic irq_cond;
	logic start_any;
	logic start_irq;
	logic finish_short;
	logic finish_irq;

	assign in_idle = (state == IDLE);

	// Interrupt accepted only when unlocked and enabled in the PSR
	assign irq_cond = irq_req && !irq_lock && sysreg_psr[PSR_IRQ_ENABLE_BIT];

	// Next state, priority follows the reference order
	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (irq_cond && branch_valid) begin
					next_state = JUMP_IRQ_CALL;
				end else if (irq_cond) begin
					next_state = IRQ_CALL;
				end else if (branch_valid) begin
					next_state = JUMP;
				end else if (reload_valid) begin
					next_state = RELOAD;
				end else if (return_valid) begin
					next_state = IRQ_RETURN;
				end
			end
			JUMP_IRQ_CALL, IRQ_CALL: begin
				if (fetch_done) begin
					next_state = IDLE;
				end
			end
			// Single cycle sequences
			JUMP, RELOAD, IRQ_RETURN: begin
				next_state = IDLE;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	assign start_any = in_idle && (next_state != IDLE);
	assign start_irq = in_idle && ((next_state == JUMP_IRQ_CALL) || (next_state == IRQ_CALL));

	assign finish_short = (state == JUMP) || (state == RELOAD) || (state == IRQ_RETURN);
	assign finish_irq = ((state == JUMP_IRQ_CALL) || (state == IRQ_CALL)) && fetch_done;

	// Vector fetch kicked off together with the state change
	assign fetch_start = start_irq;

	// Redirect strobes toward the register set logic
	assign redirect.jump_take = in_idle &&
		((next_state == JUMP_IRQ_CALL) || (next_state == JUMP) || (next_state == RELOAD));
	assign redirect.irq_done = finish_irq;
	assign redirect.return_take = in_idle && (next_state == IRQ_RETURN);
	assign redirect.idle_quiet = in_idle && (next_state == IDLE);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= IDLE;
		end else if (reset_sync) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	// Event pulses, all registered
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			event_hold <= 1'b0;
			event_start <= 1'b0;
			event_irq_front2back <= 1'b0;
			event_irq_back2front <= 1'b0;
			event_end <= 1'b0;
		end else if (reset_sync) begin
			event_hold <= 1'b0;
			event_start <= 1'b0;
			event_irq_front2back <= 1'b0;
			event_irq_back2front <= 1'b0;
			event_end <= 1'b0;
		end else begin
			// Hold only changes while idle, so it drops with the end pulse
			if (in_idle) begin
				event_hold <= start_any;
			end
			event_start <= start_any;
			event_irq_front2back <= start_irq;
			event_irq_back2front <= redirect.return_take;
			event_end <= finish_short || finish_irq;
		end
	end

	// Acknowledge once the handler address is known
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			irq_ack <= 1'b0;
		end else if (reset_sync) begin
			irq_ack <= 1'b0;
		end else begin
			irq_ack <= finish_irq;
		end
	end

endmodule

`default_nettype wire

//--- hdl/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

	// Width of the control state register
	localparam int CTRL_STATE_W = 3;

	// Control sequences of the pipeline controller
	typedef enum logic [CTRL_STATE_W-1:0] {
		IDLE          = 3'h0,
		JUMP_IRQ_CALL = 3'h1,
		JUMP          = 3'h2,
		IRQ_CALL      = 3'h3,
		IRQ_RETURN    = 3'h4,
		RELOAD        = 3'h5
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/pipe_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_ctrl_top
	import core_arch_pkg::*;
(
	input  logic        iCLOCK,
	input  logic        inRESET,
	input  logic        reset_sync,
	// Execute stage
	input  word_t       jump_addr,
	input  logic        branch_valid,
	input  logic        return_valid,
	input  logic        reload_valid,
	// Interrupt controller
	input  logic        irq_req,
	input  irq_num_t    irq_num,
	output logic        irq_ack,
	// System registers
	input  word_t       sysreg_psr,
	input  word_t       sysreg_pcr,
	input  word_t       sysreg_ppcr,
	input  word_t       sysreg_idtr,
	input  logic        irq_lock,
	// Load/store port
	output logic        ldst_use,
	output logic        ldst_req,
	output ldst_order_t ldst_order,
	output logic        ldst_rw,
	output word_t       ldst_addr,
	output word_t       ldst_data,
	input  logic        ldst_busy,
	input  logic        ldst_valid,
	input  word_t       ldst_rdata,
	// Pipeline events
	output logic        event_hold,
	output logic        event_start,
	output logic        event_irq_front2back,
	output logic        event_irq_back2front,
	output logic        event_end,
	output logic        pcr_set,
	output word_t       pcr,
	output logic        ppcr_set,
	output word_t       ppcr
);

	logic fetch_start;
	logic fetch_done;

	redirect_if redirect();

	pipe_ctrl_fsm u_fsm (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.reset_sync(reset_sync),
		.branch_valid(branch_valid),
		.return_valid(return_valid),
		.reload_valid(reload_valid),
		.irq_req(irq_req),
		.irq_lock(irq_lock),
		.sysreg_psr(sysreg_psr),
		.fetch_done(fetch_done),
		.fetch_start(fetch_start),
		.redirect(redirect.ctrl),
		.event_hold(event_hold),
		.event_start(event_start),
		.event_irq_front2back(event_irq_front2back),
		.event_irq_back2front(event_irq_back2front),
		.event_end(event_end),
		.irq_ack(irq_ack)
	);

	// Handler goes straight onto the redirect bundle
	irq_vector_fetch u_fetch (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.reset_sync(reset_sync),
		.start(fetch_start),
		.irq_num(irq_num),
		.idtr(sysreg_idtr),
		.done(fetch_done),
		.handler(redirect.handler),
		.ldst_use(ldst_use),
		.ldst_req(ldst_req),
		.ldst_order(ldst_order),
		.ldst_rw(ldst_rw),
		.ldst_addr(ldst_addr),
		.ldst_data(ldst_data),
		.ldst_busy(ldst_busy),
		.ldst_valid(ldst_valid),
		.ldst_rdata(ldst_rdata)
	);

	sysreg_set u_sysreg (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.reset_sync(reset_sync),
		.redirect(redirect.regs),
		.jump_addr(jump_addr),
		.sysreg_pcr(sysreg_pcr),
		.sysreg_ppcr(sysreg_ppcr),
		.pcr_set(pcr_set),
		.pcr(pcr),
		.ppcr_set(ppcr_set),
		.ppcr(ppcr)
	);

endmodule

`default_nettype wire

//--- hdl/redirect_if.sv
`timescale 1ns/1ns
`default_nettype none

interface redirect_if import core_arch_pkg::*; ();

	// Jump or reload starts, new PC from the execute stage
	logic jump_take;
	// Vector fetch finished, handler address below
	logic irq_done;
	logic return_take;
	// Idle with nothing starting
	logic idle_quiet;
	word_t handler;

	modport ctrl (
		output jump_take,
		output irq_done,
		output return_take,
		output idle_quiet
	);

	modport regs (
		input jump_take,
		input irq_done,
		input return_take,
		input idle_quiet,
		input handler
	);

endinterface

`default_nettype wire

//--- hdl/sysreg_set.sv
`timescale 1ns/1ns
`default_nettype none

module sysreg_set
	import core_arch_pkg::*;
(
	input  logic        iCLOCK,
	input  logic        inRESET,
	input  logic        reset_sync,
	redirect_if.regs    redirect,
	input  word_t       jump_addr,
	input  word_t       sysreg_pcr,
	input  word_t       sysreg_ppcr,
	output logic        pcr_set,
	output word_t       pcr,
	output logic        ppcr_set,
	output word_t       ppcr
);

	logic pcr_load;
	word_t pcr_next;

	// New PC source, only one strobe fires in a cycle
	always_comb begin
		pcr_load = 1'b1;
		pcr_next = jump_addr;
		if (redirect.jump_take) begin
			pcr_next = jump_addr;
		end else if (redirect.irq_done) begin
			pcr_next = redirect.handler;
		end else if (redirect.return_take) begin
			pcr_next = sysreg_ppcr;
		end else begin
			pcr_load = 1'b0;
		end
	end

	// Set event stays up until the machine idles with nothing new
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pcr_set <= 1'b0;
			pcr <= '0;
		end else if (reset_sync) begin
			pcr_set <= 1'b0;
			pcr <= '0;
		end else if (pcr_load) begin
			pcr_set <= 1'b1;
			pcr <= pcr_next;
		end else if (redirect.idle_quiet) begin
			pcr_set <= 1'b0;
			pcr <= '0;
		end
	end

	// Previous PC saved once per interrupt entry
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ppcr_set <= 1'b0;
		end else if (reset_sync) begin
			ppcr_set <= 1'b0;
		end else begin
			ppcr_set <= redirect.irq_done;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (redirect.irq_done) begin
			ppcr <= sysreg_pcr;
		end
	end

endmodule

`default_nettype wire

//--- project.f
hdl/core_arch_pkg.sv
hdl/pipe_ctrl_pkg.sv
hdl/redirect_if.sv
hdl/pipe_ctrl_fsm.sv
hdl/irq_vector_fetch.sv
hdl/sysreg_set.sv
hdl/pipe_ctrl_top.sv
dv/pipe_ctrl_checker.sv
dv/tb_pipe_ctrl.sv
